// File: rtl/cdbPkg.sv
package cdbPkg;

  parameter int dataWidth = 32;   // Operand and result width
  parameter int robTagWidth = 3;  // 8 ROB entries
  parameter int ctrlWidth = 5;    // Branch control field on the bus

  // ALU operations
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluXor = 3'd4,
    aluSll = 3'd5,
    aluSlt = 3'd6   // Signed compare
  } AluOp;

  // Branch conditions, also the low bits of pcControl
  typedef enum logic [2:0] {
    brEq     = 3'd0,
    brNe     = 3'd1,
    brLt     = 3'd2,  // Signed
    brAlways = 3'd3
  } BranchCond;

  typedef struct packed {
    logic                 isBranch;      // Steers to the branch unit
    AluOp                 aluOp;
    BranchCond            branchCond;
    logic [dataWidth-1:0] operandA;
    logic [dataWidth-1:0] operandB;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] offset;        // Branch displacement
    logic                 predictTaken;
  } IssueOp;

  // Held by a unit until the arbiter takes it
  typedef struct packed {
    logic [robTagWidth-1:0] robTag;
    logic [dataWidth-1:0]   value;
    logic [dataWidth-1:0]   targetAddress;
    logic [ctrlWidth-1:0]   pcControl;   // {mispredict, taken, cond}
  } UnitResult;

  typedef struct packed {
    logic                   valid;
    logic [robTagWidth-1:0] robTag;
    logic [dataWidth-1:0]   result;
    logic [dataWidth-1:0]   targetAddress;
    logic                   isControl;   // Branch unit won the bus
    logic [ctrlWidth-1:0]   pcControl;
  } CdbBroadcast;

  typedef struct packed {
    logic                   valid;
    logic [robTagWidth-1:0] robTag;
    logic [dataWidth-1:0]   value;
    logic                   redirect;         // Mispredicted branch retires
    logic [dataWidth-1:0]   redirectAddress;
  } CommitInfo;

endpackage

// File: rtl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           flush,
  input  logic                           start,
  input  cdbPkg::IssueOp                 op,
  input  logic [cdbPkg::robTagWidth-1:0] robTag,
  input  logic                           available,
  output logic                           dataBusReq,
  output cdbPkg::UnitResult              result,
  output logic                           free
);
  import cdbPkg::*;

  logic                 busy;      // Holding a result for the bus
  logic                 granted;
  logic [dataWidth-1:0] aluValue;

  // Integer datapath
  always_comb begin
    aluValue = '0;
    case (op.aluOp)
      aluAdd: aluValue = op.operandA + op.operandB;
      aluSub: aluValue = op.operandA - op.operandB;
      aluAnd: aluValue = op.operandA & op.operandB;
      aluOr:  aluValue = op.operandA | op.operandB;
      aluXor: aluValue = op.operandA ^ op.operandB;
      aluSll: aluValue = op.operandA << op.operandB[4:0];  // Low five bits only
      aluSlt: aluValue[0] = $signed(op.operandA) < $signed(op.operandB);
      default: aluValue = '0;  // Unused encoding
    endcase
  end

  assign granted    = busy && available;
  assign dataBusReq = busy;
  assign free       = !busy || granted;  // Allows back-to-back issue

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;  // Drop held work
    end else if (start) begin
      busy <= 1'b1;  // New op wins over a same-cycle grant
    end else if (granted) begin
      busy <= 1'b0;
    end
  end

  // Tagged result, captured at the issue edge
  always_ff @(posedge clk) begin
    if (start) begin
      result.robTag        <= robTag;
      result.value         <= aluValue;
      result.targetAddress <= '0;  // No control flow here
      result.pcControl     <= '0;
    end
  end

endmodule

// File: rtl/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           flush,
  input  logic                           start,
  input  cdbPkg::IssueOp                 op,
  input  logic [cdbPkg::robTagWidth-1:0] robTag,
  input  logic                           available,
  output logic                           dataBusReq,
  output cdbPkg::UnitResult              result,
  output logic                           free
);
  import cdbPkg::*;

  logic                 busy;
  logic                 granted;
  logic                 taken;
  logic                 mispredict;
  logic [dataWidth-1:0] linkValue;
  logic [dataWidth-1:0] target;

  // Resolve the condition
  always_comb begin
    case (op.branchCond)
      brEq:     taken = (op.operandA == op.operandB);
      brNe:     taken = (op.operandA != op.operandB);
      brLt:     taken = $signed(op.operandA) < $signed(op.operandB);
      brAlways: taken = 1'b1;
      default:  taken = 1'b0;
    endcase
  end

  assign mispredict = taken != op.predictTaken;  // Prediction was wrong
  assign linkValue  = op.pc + dataWidth'(4);     // Return address
  assign target     = op.pc + op.offset;

  assign granted    = busy && available;
  assign dataBusReq = busy;
  assign free       = !busy || granted;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy <= 1'b0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (granted) begin
      busy <= 1'b0;  // Result left on the bus
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      result.robTag        <= robTag;
      result.value         <= linkValue;
      result.targetAddress <= target;
      result.pcControl     <= {mispredict, taken, op.branchCond};  // Bit 4 down to cond
    end
  end

endmodule

// File: rtl/cdbArbiter.sv
`timescale 1ns/1ps

module cdbArbiter (
  input  logic                clk,
  input  logic                rstN,
  input  logic                flush,
  input  logic                aluReq,
  input  logic                branchReq,
  input  cdbPkg::UnitResult   aluResult,
  input  cdbPkg::UnitResult   branchResult,
  output logic                aluAvailable,
  output logic                branchAvailable,
  output cdbPkg::CdbBroadcast cdbOut
);
  import cdbPkg::*;

  logic      pointer;      // 0 prefers ALU, 1 prefers branch
  logic      grantAlu;
  logic      grantBranch;
  logic      anyGrant;
  UnitResult winner;       // Selected payload

  // Round-robin pick between the two requesters
  always_comb begin
    grantAlu    = aluReq && (!pointer || !branchReq);
    grantBranch = branchReq && (pointer || !aluReq);
    anyGrant    = grantAlu || grantBranch;
    if (grantBranch) begin
      winner = branchResult;
    end else begin
      winner = aluResult;
    end
  end

  // Free when granted or idle, stalled otherwise
  assign aluAvailable    = grantAlu || !aluReq;
  assign branchAvailable = grantBranch || !branchReq;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pointer <= 1'b0;
      cdbOut  <= '0;
    end else if (flush) begin
      cdbOut.valid <= 1'b0;  // Squash this edge's broadcast
    end else begin
      cdbOut.valid <= anyGrant;
      if (anyGrant) begin
        pointer              <= grantAlu;  // Other unit gets priority next
        cdbOut.robTag        <= winner.robTag;
        cdbOut.result        <= winner.value;
        cdbOut.targetAddress <= winner.targetAddress;
        cdbOut.isControl     <= grantBranch;
        cdbOut.pcControl     <= winner.pcControl;
      end
    end
  end

endmodule

// File: rtl/reorderBuffer.sv
`timescale 1ns/1ps

module reorderBuffer #(
  parameter int robDepth = 8  // Equals 2**robTagWidth
) (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           alloc,
  input  cdbPkg::CdbBroadcast            cdbIn,
  output logic [cdbPkg::robTagWidth-1:0] allocTag,
  output logic                           robFull,
  output logic                           flush,
  output cdbPkg::CommitInfo              commit
);
  import cdbPkg::*;

  logic [robTagWidth-1:0] head;    // Oldest entry
  logic [robTagWidth-1:0] tail;    // Next tag to hand out
  logic [robTagWidth:0]   count;
  logic [robDepth-1:0]    done;    // Result seen on the bus
  logic [robDepth-1:0]    mispredict;
  logic [dataWidth-1:0]   valueMem [robDepth];
  logic [dataWidth-1:0]   targetMem [robDepth];
  logic                   commitValid;

  assign allocTag    = tail;
  assign robFull     = (count == (robTagWidth + 1)'(robDepth));
  assign commitValid = (count != '0) && done[head];  // In-order retire

  always_comb begin
    commit.valid           = commitValid;
    commit.robTag          = head;
    commit.value           = valueMem[head];
    commit.redirect        = commitValid && mispredict[head];
    commit.redirectAddress = targetMem[head];
  end

  assign flush = commit.redirect;  // Wrong path behind the head

  // Capture broadcast payload by tag
  always_ff @(posedge clk) begin
    if (cdbIn.valid) begin
      valueMem[cdbIn.robTag]   <= cdbIn.result;
      targetMem[cdbIn.robTag]  <= cdbIn.targetAddress;
      mispredict[cdbIn.robTag] <= cdbIn.isControl && cdbIn.pcControl[ctrlWidth-1];
    end
  end

  // Pointers, occupancy and done flags
  always_ff @(posedge clk) begin
    if (!rstN) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else if (flush) begin
      head  <= '0;  // Everything in flight is discarded
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (commitValid) begin
        head       <= head + 1'b1;
        done[head] <= 1'b0;
      end
      if (alloc) begin
        tail       <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (cdbIn.valid) begin
        done[cdbIn.robTag] <= 1'b1;  // Ready to retire next cycle
      end
      case ({alloc, commitValid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

// File: rtl/cdbCore.sv
`timescale 1ns/1ps

module cdbCore #(
  parameter int robDepth = 8
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                issueValid,
  input  cdbPkg::IssueOp      issueOp,
  output logic                issueReady,
  output cdbPkg::CdbBroadcast cdbOut,
  output cdbPkg::CommitInfo   commit
);
  import cdbPkg::*;

  logic                   outOfReset;   // Holds issue off for the first cycle
  logic                   transfer;
  logic                   unitFree;
  logic                   aluStart;
  logic                   branchStart;
  logic                   aluReq;
  logic                   branchReq;
  logic                   aluAvailable;
  logic                   branchAvailable;
  logic                   aluFree;
  logic                   branchFree;
  logic                   robFull;
  logic                   flush;
  logic [robTagWidth-1:0] allocTag;
  UnitResult              aluResult;
  UnitResult              branchResult;

  always_ff @(posedge clk) begin
    if (!rstN) outOfReset <= 1'b0;
    else       outOfReset <= 1'b1;
  end

  assign unitFree    = issueOp.isBranch ? branchFree : aluFree;  // Target unit only
  assign issueReady  = outOfReset && !robFull && !flush && unitFree;
  assign transfer    = issueValid && issueReady;
  assign aluStart    = transfer && !issueOp.isBranch;
  assign branchStart = transfer && issueOp.isBranch;

  aluUnit aluUnit_inst (
    .clk(clk), .rstN(rstN), .flush(flush), .start(aluStart), .op(issueOp),
    .robTag(allocTag), .available(aluAvailable), .dataBusReq(aluReq),
    .result(aluResult), .free(aluFree)
  );

  branchUnit branchUnit_inst (
    .clk(clk), .rstN(rstN), .flush(flush), .start(branchStart), .op(issueOp),
    .robTag(allocTag), .available(branchAvailable), .dataBusReq(branchReq),
    .result(branchResult), .free(branchFree)
  );

  cdbArbiter cdbArbiter_inst (
    .clk(clk), .rstN(rstN), .flush(flush), .aluReq(aluReq), .branchReq(branchReq),
    .aluResult(aluResult), .branchResult(branchResult), .aluAvailable(aluAvailable),
    .branchAvailable(branchAvailable), .cdbOut(cdbOut)
  );

  reorderBuffer #(.robDepth(robDepth)) reorderBuffer_inst (
    .clk(clk), .rstN(rstN), .alloc(transfer), .cdbIn(cdbOut), .allocTag(allocTag),
    .robFull(robFull), .flush(flush), .commit(commit)
  );

endmodule

// File: sim/cdbChecker.sv
`timescale 1ns/1ps

module cdbChecker #(
  parameter int robDepth = 8
) (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              issueValid,
  input  logic                              issueReady,
  input  cdbPkg::IssueOp                    issueOp,
  input  logic [cdbPkg::dataWidth-1:0]      refValue,    // Model output for issueOp
  input  logic [cdbPkg::dataWidth-1:0]      refTarget,
  input  logic                              refTaken,
  input  logic                              refMispredict,
  input  cdbPkg::CdbBroadcast               cdbOut,
  input  cdbPkg::CommitInfo                 commit,
  output int                                errorCount,
  output int                                checkCount,
  output int                                pending      // Outstanding ops
);
  import cdbPkg::*;

  // One accepted operation and what it should produce
  typedef struct packed {
    logic [robTagWidth-1:0] tag;
    logic                   isBranch;
    logic                   mispredict;
    logic                   taken;
    BranchCond              cond;        // Low bits of pcControl
    logic [dataWidth-1:0]   value;
    logic [dataWidth-1:0]   target;
  } Expected;

  Expected                progQ[$];               // Oldest first in program order
  int                     bcastCount [robDepth];  // Broadcasts seen per tag
  logic [robTagWidth-1:0] nextTag;
  logic                   anyIssued;
  logic                   firstCycle;             // First cycle out of reset

  task automatic compareValue(input string name, input logic [dataWidth-1:0] expected,
                              input logic [dataWidth-1:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic reportProblem(input string text);
    checkCount++;
    errorCount++;
    $display("%s at %0t", text, $time);
  endtask

  function automatic int findTag(input logic [robTagWidth-1:0] tag);
    for (int i = 0; i < progQ.size(); i++) begin
      if (progQ[i].tag == tag) return i;
    end
    return -1;  // Not outstanding
  endfunction

  // Values read here are the ones from before this edge
  always @(posedge clk) begin
    int      idx;
    Expected head;
    Expected entry;
    if (!rstN) begin
      progQ.delete();
      nextTag    = '0;
      anyIssued  = 1'b0;
      firstCycle = 1'b1;
      pending    = 0;
    end else begin
      if (firstCycle && issueReady) reportProblem("issueReady high in first cycle after reset");
      firstCycle = 1'b0;
      if (!anyIssued && (cdbOut.valid || commit.valid)) begin
        reportProblem("Bus or commit active before any issue");
      end
      if (progQ.size() >= robDepth && issueReady) begin
        reportProblem("issueReady high with the reorder buffer full");
      end

      // Bus side first so a flush cycle still finds its tag
      if (cdbOut.valid) begin
        idx = findTag(cdbOut.robTag);
        if (idx < 0) begin
          reportProblem("Broadcast carries a tag that is not outstanding");
        end else begin
          if (bcastCount[cdbOut.robTag] != 0) reportProblem("Tag broadcast more than once");
          bcastCount[cdbOut.robTag]++;
          compareValue("busResult", progQ[idx].value, cdbOut.result);
          compareValue("busIsControl", progQ[idx].isBranch, cdbOut.isControl);
          if (progQ[idx].isBranch) begin
            compareValue("busTarget", progQ[idx].target, cdbOut.targetAddress);
            compareValue("busTaken", progQ[idx].taken, cdbOut.pcControl[3]);
            compareValue("busMispredict", progQ[idx].mispredict, cdbOut.pcControl[4]);
            compareValue("busCond", progQ[idx].cond, cdbOut.pcControl[2:0]);
          end
        end
      end

      // Retirement in program order
      if (commit.valid) begin
        if (progQ.size() == 0) begin
          reportProblem("Commit with no outstanding operation");
        end else begin
          head = progQ.pop_front();
          compareValue("commitTag", head.tag, commit.robTag);
          compareValue("commitValue", head.value, commit.value);
          compareValue("commitBroadcasts", 1, bcastCount[head.tag]);
          compareValue("commitRedirect", head.mispredict, commit.redirect);
          if (head.mispredict) compareValue("redirectAddress", head.target,
                                            commit.redirectAddress);
        end
        if (commit.redirect) begin
          progQ.delete();  // Younger ops were wrong path
          nextTag = '0;
        end
      end

      if (issueValid && issueReady) begin
        if (commit.valid && commit.redirect) reportProblem("Issue accepted during a flush");
        entry.tag        = nextTag;
        entry.isBranch   = issueOp.isBranch;
        entry.mispredict = refMispredict;
        entry.taken      = refTaken;
        entry.cond       = issueOp.branchCond;
        entry.value      = refValue;
        entry.target     = refTarget;
        progQ.push_back(entry);
        bcastCount[nextTag] = 0;
        nextTag   = nextTag + 1'b1;  // Tags wrap with the buffer
        anyIssued = 1'b1;
        if (progQ.size() > robDepth) reportProblem("More operations outstanding than entries");
      end
      pending = progQ.size();
    end
  end

endmodule

// File: sim/cdbTb.sv
`timescale 1ns/1ps

module cdbTb;
  import cdbPkg::*;

  localparam int robDepth      = 8;
  localparam int opCount       = 300;
  localparam int timeoutCycles = opCount * 12 + 50;

  logic                 clk;
  logic                 rstN;
  logic                 issueValid;
  IssueOp               issueOp;
  logic                 issueReady;
  CdbBroadcast          cdbOut;
  CommitInfo            commit;
  logic [dataWidth-1:0] refValue;
  logic [dataWidth-1:0] refTarget;
  logic                 refTaken;
  logic                 refMispredict;
  int                   errorCount;
  int                   checkCount;
  int                   pending;
  int                   cycleCount = 0;
  integer               seed;

  // Expected outcome straight from the ISA rules, packed as {mispredict, taken, target, value}
  function automatic logic [2*dataWidth+1:0] refExecute(input IssueOp op);
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;
    logic [dataWidth-1:0] value;
    logic [dataWidth-1:0] target;
    logic                 lessSigned;
    logic                 taken;
    a          = op.operandA;
    b          = op.operandB;
    value      = '0;
    target     = '0;
    taken      = 1'b0;
    lessSigned = (a[31] != b[31]) ? a[31] : (a < b);  // Sign bits decide first
    if (op.isBranch) begin
      case (op.branchCond)
        brEq:    taken = (a == b);
        brNe:    taken = (a != b);
        brLt:    taken = lessSigned;
        default: taken = 1'b1;
      endcase
      value  = op.pc + 32'd4;  // Link
      target = op.pc + op.offset;
    end else begin
      case (op.aluOp)
        aluAdd:  value = a + b;
        aluSub:  value = a + ~b + 32'd1;
        aluAnd:  value = a & b;
        aluOr:   value = a | b;
        aluXor:  value = a ^ b;
        aluSll:  value = a << (b % 32);
        aluSlt:  value = {31'b0, lessSigned};
        default: value = '0;
      endcase
    end
    return {op.isBranch && (taken != op.predictTaken), taken, target, value};
  endfunction

  function automatic IssueOp randomOp();
    IssueOp      op;
    logic [31:0] r;
    logic [31:0] pcDraw;
    r               = $random(seed);
    pcDraw          = $random(seed);
    op              = '0;
    op.isBranch     = (r[1:0] == 2'b00);  // About one op in four
    op.aluOp        = AluOp'(3'(r[7:4] % 4'd7));
    op.branchCond   = BranchCond'({1'b0, r[9:8]});
    op.predictTaken = r[10];
    op.operandA     = $random(seed);
    op.operandB     = r[11] ? op.operandA : $random(seed);  // Equal half the time
    op.pc           = {pcDraw[31:2], 2'b00};
    op.offset       = {{20{r[23]}}, r[23:14], 2'b00};
    return op;
  endfunction

  assign {refMispredict, refTaken, refTarget, refValue} = refExecute(issueOp);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  cdbCore #(.robDepth(robDepth)) cdbCore_inst (
    .clk(clk), .rstN(rstN), .issueValid(issueValid), .issueOp(issueOp),
    .issueReady(issueReady), .cdbOut(cdbOut), .commit(commit)
  );

  cdbChecker #(.robDepth(robDepth)) cdbChecker_inst (
    .clk(clk), .rstN(rstN), .issueValid(issueValid), .issueReady(issueReady),
    .issueOp(issueOp), .refValue(refValue), .refTarget(refTarget), .refTaken(refTaken),
    .refMispredict(refMispredict), .cdbOut(cdbOut), .commit(commit),
    .errorCount(errorCount), .checkCount(checkCount), .pending(pending)
  );

  // Program stimulus, inputs change on the falling edge
  initial begin
    logic [31:0] gapDraw;
    seed       = 32'hae90;
    rstN       = 1'b0;
    issueValid = 1'b0;
    issueOp    = '0;
    repeat (5) @(negedge clk);
    rstN = 1'b1;
    for (int n = 0; n < opCount; n++) begin
      gapDraw = $random(seed);
      if (gapDraw[2:0] == 3'd0) begin  // Occasional idle gap between bursts
        issueValid = 1'b0;
        repeat (gapDraw[4:3] + 1) @(negedge clk);
      end
      issueOp    = randomOp();
      issueValid = 1'b1;  // Held until accepted
      @(posedge clk);
      while (!issueReady) @(posedge clk);
      @(negedge clk);
    end
    issueValid = 1'b0;
    while (pending != 0) @(negedge clk);  // Drain
    repeat (4) @(negedge clk);
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Run did not finish within %0d cycles", timeoutCycles);
      $display("%0d checks, %0d errors", checkCount, errorCount);
      $display("test failed");
      $finish;
    end
  end

endmodule

// File: build.f
rtl/cdbPkg.sv
rtl/aluUnit.sv
rtl/branchUnit.sv
rtl/cdbArbiter.sv
rtl/reorderBuffer.sv
rtl/cdbCore.sv
sim/cdbChecker.sv
sim/cdbTb.sv
